// ==== run_sim.sh ====
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit \
    -Mdir obj_dir -f sources.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_csr_unit > sim.log 2>&1
cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+verilog
verilog/csr_types_pkg.sv
verilog/trap_types_pkg.sv
verilog/csr_write_merge.sv
verilog/csr_access_seq.sv
verilog/csr_regfile.sv
verilog/csr_unit.sv
tests/tb_csr_unit.sv

// ==== tests/tb_csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module tb_csr_unit;

    logic                        clk;
    logic                        arst_n;
    logic                        csr_req;
    csr_types_pkg::csr_addr_t    csr_addr;
    csr_types_pkg::csr_wmode_t   csr_wmode;
    csr_types_pkg::csr_data_t    csr_wmask;
    logic                        csr_src_zero;
    csr_types_pkg::priv_t        cur_priv;
    logic                        csr_done;
    csr_types_pkg::csr_data_t    csr_rdata;
    logic                        csr_illegal;
    logic                        trap_req;
    logic                        trap_irq;
    trap_types_pkg::epc_t        trap_epc;
    trap_types_pkg::trap_cause_t trap_cause;
    logic                        mret_req;
    trap_types_pkg::tvec_t       trap_tvec;
    trap_types_pkg::epc_t        ret_epc;
    trap_types_pkg::irq_mask_t   irq_pending;
    logic                        irq_take;
    trap_types_pkg::trap_cause_t irq_cause;

    // Shadow copies of the writable CSRs.
    logic [31:0] m_mscratch;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic        m_st_mie;
    logic        m_st_mpie;
    logic [31:0] lfsr_state;

    csr_unit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else report_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // New CSR value from the write, set and clear rules.
    function automatic logic [31:0] expected_merge(input logic [31:0] old, input logic [1:0] mode,
                                                   input logic [31:0] op, input logic src_zero);
        if (mode == `CSR_WMODE_WRITE) begin
            return op;
        end else if (src_zero) begin
            return old;
        end else if (mode == `CSR_WMODE_SET) begin
            return old | op;
        end
        return old & ~op;
    endfunction

    function automatic logic [31:0] mstatus_value();
        logic [31:0] v;
        v = '0;
        v[`MSTATUS_MIE_BIT]  = m_st_mie;
        v[`MSTATUS_MPIE_BIT] = m_st_mpie;
        return v;
    endfunction

    // One access with the response sampled on the falling edge.
    task automatic issue_access(input csr_types_pkg::csr_addr_t addr, input logic [1:0] mode,
                                input logic [31:0] op, input logic src_zero,
                                input csr_types_pkg::priv_t priv,
                                output logic [31:0] rdata, output logic illegal);
        int waited;
        waited = 0;
        @(posedge clk);
        csr_req      <= 1'b1;
        csr_addr     <= addr;
        csr_wmode    <= mode;
        csr_wmask    <= op;
        csr_src_zero <= src_zero;
        cur_priv     <= priv;
        @(posedge clk);
        csr_req <= 1'b0;
        @(negedge clk);
        while (!csr_done) begin
            waited++;
            if (waited > 8) begin
                report_error("Timeout while waiting for csr_done");
            end
            @(negedge clk);
        end
        rdata   = csr_rdata;
        illegal = csr_illegal;
    endtask

    task automatic expect_access(input csr_types_pkg::csr_addr_t addr, input logic [1:0] mode,
                                 input logic [31:0] op, input logic src_zero,
                                 input csr_types_pkg::priv_t priv,
                                 input logic [31:0] exp_rdata, input logic exp_illegal);
        logic [31:0] rdata;
        logic        illegal;
        issue_access(addr, mode, op, src_zero, priv, rdata, illegal);
        check_value("csr_illegal", 32'(illegal), 32'(exp_illegal));
        check_value("csr_rdata", rdata, exp_rdata);
    endtask

    // Set with a zero source is a pure read.
    task automatic expect_read(input csr_types_pkg::csr_addr_t addr, input logic [31:0] exp);
        expect_access(addr, `CSR_WMODE_SET, '0, 1'b1, csr_types_pkg::priv_machine, exp, 1'b0);
    endtask

    task automatic write_mstatus(input logic [31:0] val);
        expect_access(`CSR_ADDR_MSTATUS, `CSR_WMODE_WRITE, val, 1'b0,
                      csr_types_pkg::priv_machine, mstatus_value(), 1'b0);
        m_st_mie  = val[`MSTATUS_MIE_BIT];
        m_st_mpie = val[`MSTATUS_MPIE_BIT];
    endtask

    task automatic pulse_trap(input logic irq, input logic [29:0] epc, input logic [3:0] cause);
        logic [29:0] exp_vec;
        @(posedge clk);
        trap_req   <= 1'b1;
        trap_irq   <= irq;
        trap_epc   <= epc;
        trap_cause <= cause;
        @(negedge clk);
        // Vectored mode offsets interrupts only.
        exp_vec = m_mtvec[31:2];
        if (m_mtvec[0] && irq) begin
            exp_vec = exp_vec + 30'(cause);
        end
        check_value("trap_tvec", 32'(trap_tvec), 32'(exp_vec));
        @(posedge clk);
        trap_req  <= 1'b0;
        m_mepc    = {epc, 2'b00};
        m_mcause  = {irq, 27'd0, cause};
        m_st_mpie = m_st_mie;
        m_st_mie  = 1'b0;
    endtask

    task automatic pulse_mret();
        @(posedge clk);
        mret_req <= 1'b1;
        @(posedge clk);
        mret_req  <= 1'b0;
        m_st_mie  = m_st_mpie;
        m_st_mpie = 1'b1;
        @(negedge clk);
        check_value("ret_epc", 32'(ret_epc), 32'(m_mepc[31:2]));
    endtask

    // MEI over MSI over MTI.
    task automatic check_irq();
        logic [31:0] active;
        logic [3:0]  exp_cause;
        active    = irq_pending & m_mie & `CSR_IRQ_MASK;
        exp_cause = active[`IRQ_MEI] ? 4'(`IRQ_MEI) :
                    active[`IRQ_MSI] ? 4'(`IRQ_MSI) : 4'(`IRQ_MTI);
        check_value("irq_take", 32'(irq_take), 32'(m_st_mie && (active != '0)));
        if (active != '0) begin
            check_value("irq_cause", 32'(irq_cause), 32'(exp_cause));
        end
    endtask

    a_illegal_zero: assert property (@(posedge clk) disable iff (!arst_n)
        csr_illegal |-> (csr_done && (csr_rdata == '0)))
        else report_error("csr_illegal was raised without csr_done and zero read data");

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        csr_done |=> !csr_done)
        else report_error("csr_done stayed high for more than one cycle");

    // The response pulses at the edge after the request is registered.
    a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
        csr_req |-> ##2 csr_done)
        else report_error("csr_done did not pulse one cycle after the request was registered");

    initial begin
        logic [31:0]              op;
        logic [31:0]              rdata;
        logic                     illegal;
        logic [1:0]               mode;
        logic                     zero;
        csr_types_pkg::csr_addr_t addr;
        logic [31:0]              old;
        logic [31:0]              pend;
        arst_n       = 1'b0;
        csr_req      = 1'b0;
        csr_addr     = '0;
        csr_wmode    = `CSR_WMODE_WRITE;
        csr_wmask    = '0;
        csr_src_zero = 1'b0;
        cur_priv     = csr_types_pkg::priv_machine;
        trap_req     = 1'b0;
        trap_irq     = 1'b0;
        trap_epc     = '0;
        trap_cause   = '0;
        mret_req     = 1'b0;
        irq_pending  = '0;
        lfsr_state   = 32'h3391faae;
        m_mie        = '0;
        m_mtvec      = `CSR_MTVEC_RESET;
        m_st_mie     = 1'b0;
        m_st_mpie    = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);

        // Reset values.
        check_value("irq_take", 32'(irq_take), 32'd0);
        expect_read(`CSR_ADDR_MTVEC, `CSR_MTVEC_RESET);
        expect_read(`CSR_ADDR_MISA, `CSR_MISA_VALUE);
        expect_read(`CSR_ADDR_MHARTID, `CSR_MHARTID_VALUE);
        expect_read(`CSR_ADDR_MSTATUS, mstatus_value());

        // mscratch has no reset, so its first old value is not checked.
        op = take_bits(32);
        issue_access(`CSR_ADDR_MSCRATCH, `CSR_WMODE_WRITE, op, 1'b0,
                     csr_types_pkg::priv_machine, rdata, illegal);
        check_value("csr_illegal", 32'(illegal), 32'd0);
        m_mscratch = op;

        // Random write, set and clear on the writable registers.
        for (int i = 0; i < 48; i++) begin
            case (take_bits(2) % 3)
                0: addr = `CSR_ADDR_MSCRATCH;
                1: addr = `CSR_ADDR_MIE;
                default: addr = `CSR_ADDR_MTVEC;
            endcase
            old  = (addr == `CSR_ADDR_MSCRATCH) ? m_mscratch :
                   (addr == `CSR_ADDR_MIE) ? m_mie : m_mtvec;
            mode = 2'(take_bits(2));
            if (mode == `CSR_WMODE_NONE) begin
                mode = `CSR_WMODE_WRITE;
            end
            zero = 1'(take_bits(1));
            op   = take_bits(32);
            expect_access(addr, mode, op, zero, csr_types_pkg::priv_machine, old, 1'b0);
            // The mie mask keeps three lines and the mtvec mask drops bit 1.
            if (addr == `CSR_ADDR_MSCRATCH) begin
                m_mscratch = expected_merge(old, mode, op, zero);
            end else if (addr == `CSR_ADDR_MIE) begin
                m_mie = expected_merge(old, mode, op, zero) & `CSR_IRQ_MASK;
            end else begin
                m_mtvec = expected_merge(old, mode, op, zero) & 32'hFFFF_FFFD;
            end
        end
        expect_read(`CSR_ADDR_MSCRATCH, m_mscratch);
        expect_read(`CSR_ADDR_MIE, m_mie);
        expect_read(`CSR_ADDR_MTVEC, m_mtvec);

        // Illegal accesses.
        op = take_bits(32);
        expect_access(12'h7C0, `CSR_WMODE_WRITE, op, 1'b0, csr_types_pkg::priv_machine, '0, 1'b1);
        expect_access(`CSR_ADDR_MHARTID, `CSR_WMODE_WRITE, op, 1'b0,
                      csr_types_pkg::priv_machine, '0, 1'b1);
        expect_access(`CSR_ADDR_MSCRATCH, `CSR_WMODE_SET, '0, 1'b1,
                      csr_types_pkg::priv_user, '0, 1'b1);
        expect_access(`CSR_ADDR_MSCRATCH, `CSR_WMODE_WRITE, op, 1'b0,
                      csr_types_pkg::priv_user, '0, 1'b1);
        expect_read(`CSR_ADDR_MSCRATCH, m_mscratch);
        expect_read(`CSR_ADDR_MHARTID, `CSR_MHARTID_VALUE);

        // Trap entry and mret in both vector modes with and without interrupt.
        for (int i = 0; i < 8; i++) begin
            op = (take_bits(32) & 32'hFFFF_FFFE) | 32'(i[0]);
            expect_access(`CSR_ADDR_MTVEC, `CSR_WMODE_WRITE, op, 1'b0,
                          csr_types_pkg::priv_machine, m_mtvec, 1'b0);
            m_mtvec = op & 32'hFFFF_FFFD;
            write_mstatus(take_bits(32));
            pulse_trap(i[1], 30'(take_bits(30)), 4'(take_bits(4)));
            expect_read(`CSR_ADDR_MEPC, m_mepc);
            expect_read(`CSR_ADDR_MCAUSE, m_mcause);
            expect_read(`CSR_ADDR_MSTATUS, mstatus_value());
            pulse_mret();
            expect_read(`CSR_ADDR_MSTATUS, mstatus_value());
        end

        // Interrupt gating and mip readback.
        for (int i = 0; i < 16; i++) begin
            op = take_bits(32);
            expect_access(`CSR_ADDR_MIE, `CSR_WMODE_WRITE, op, 1'b0,
                          csr_types_pkg::priv_machine, m_mie, 1'b0);
            m_mie = op & `CSR_IRQ_MASK;
            write_mstatus(take_bits(32));
            pend = take_bits(32);
            @(posedge clk);
            irq_pending <= pend;
            @(negedge clk);
            check_irq();
            expect_read(`CSR_ADDR_MIP, pend & `CSR_IRQ_MASK);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== verilog/csr_access_seq.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_access_seq (
    input  logic                       clk,
    input  logic                       arst_n,
    // Request from the core as a one-cycle strobe.
    input  logic                       csr_req,
    input  csr_types_pkg::csr_addr_t   csr_addr,
    input  csr_types_pkg::csr_wmode_t  csr_wmode,
    input  csr_types_pkg::csr_data_t   csr_wmask,
    input  logic                       csr_src_zero,
    input  csr_types_pkg::priv_t       cur_priv,
    // Zero-latency lookup into the register file.
    output csr_types_pkg::csr_addr_t   lk_addr,
    input  logic                       lk_exists,
    input  logic                       lk_rdonly,
    input  csr_types_pkg::priv_t       lk_priv,
    input  csr_types_pkg::csr_data_t   lk_rdata,
    // Write port addressed by lk_addr.
    output logic                       wr_en,
    output csr_types_pkg::csr_data_t   wr_data,
    // Response to the core.
    output logic                       csr_done,
    output csr_types_pkg::csr_data_t   csr_rdata,
    output logic                       csr_illegal
);

    // Stage register. Only the valid bit is control state.
    logic                       req_q;
    csr_types_pkg::csr_addr_t   addr_q;
    csr_types_pkg::csr_wmode_t  wmode_q;
    csr_types_pkg::csr_data_t   wmask_q;
    logic                       src_zero_q;
    csr_types_pkg::priv_t       priv_q;

    // Check results for the staged access.
    logic                       acc_writes;
    logic                       acc_legal;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= csr_req;
        end
    end

    // Payload is captured only with a new request.
    always_ff @(posedge clk) begin
        if (csr_req) begin
            addr_q     <= csr_addr;
            wmode_q    <= csr_wmode;
            wmask_q    <= csr_wmask;
            src_zero_q <= csr_src_zero;
            priv_q     <= cur_priv;
        end
    end

    assign lk_addr = addr_q;

    // Set and clear with x0 / zero immediate are pure reads.
    // Mode 00 is excluded upstream, so anything but write hinges on src_zero.
    assign acc_writes = (wmode_q == `CSR_WMODE_WRITE) || !src_zero_q;

    // Exists, enough privilege, and no write into read-only space.
    assign acc_legal = lk_exists && (priv_q >= lk_priv) && !(acc_writes && lk_rdonly);

    assign wr_en = req_q && acc_legal && acc_writes;

    csr_write_merge u_merge (
        .wmask (wmask_q),
        .rdata (lk_rdata),
        .wmode (wmode_q),
        .wdata (wr_data)
    );

    // Response goes out at the same edge that commits the write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_done    <= 1'b0;
            csr_illegal <= 1'b0;
        end else begin
            csr_done    <= req_q;
            csr_illegal <= req_q && !acc_legal;
        end
    end

    // Old value on a legal access, zero on an illegal one.
    always_ff @(posedge clk) begin
        if (req_q) begin
            csr_rdata <= acc_legal ? lk_rdata : '0;
        end
    end

    // The core never issues a no-access mode.
    a_req_mode: assert property (@(posedge clk) disable iff (!arst_n)
        csr_req |-> (csr_wmode != `CSR_WMODE_NONE));

    // A write must never commit the merge block's don't-care result.
    a_wr_mode: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> (wmode_q != `CSR_WMODE_NONE));

endmodule

// ==== verilog/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Machine-mode CSR addresses.
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MHARTID    12'hF14

// Fixed and reset values. RV32I with MXL = 1.
`define CSR_MISA_VALUE      32'h4000_0100
`define CSR_MVENDORID_VALUE 32'h0000_0000
`define CSR_MHARTID_VALUE   32'h0000_0000
`define CSR_MTVEC_RESET     32'h0000_0100

// Write modes as encoded in funct3[1:0].
`define CSR_WMODE_NONE      2'b00
`define CSR_WMODE_WRITE     2'b01
`define CSR_WMODE_SET       2'b10
`define CSR_WMODE_CLEAR     2'b11

// Status bits and machine interrupt lines.
`define MSTATUS_MIE_BIT     3
`define MSTATUS_MPIE_BIT    7
`define IRQ_MSI             3
`define IRQ_MTI             7
`define IRQ_MEI             11
`define CSR_IRQ_MASK        32'h0000_0888

`endif

// ==== verilog/csr_regfile.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_regfile (
    input  logic                        clk,
    input  logic                        arst_n,
    // Lookup answered in the same cycle.
    input  csr_types_pkg::csr_addr_t    lk_addr,
    output logic                        lk_exists,
    output logic                        lk_rdonly,
    output csr_types_pkg::priv_t        lk_priv,
    output csr_types_pkg::csr_data_t    lk_rdata,
    // Write to the looked-up address.
    input  logic                        wr_en,
    input  csr_types_pkg::csr_data_t    wr_data,
    // Trap entry.
    input  logic                        trap_req,
    input  logic                        trap_irq,
    input  trap_types_pkg::epc_t        trap_epc,
    input  trap_types_pkg::trap_cause_t trap_cause,
    // Return from trap.
    input  logic                        mret_req,
    // Level-sensitive interrupt lines.
    input  trap_types_pkg::irq_mask_t   irq_pending,
    // To the core.
    output trap_types_pkg::tvec_t       trap_tvec,
    output trap_types_pkg::epc_t        ret_epc,
    output logic                        irq_take,
    output trap_types_pkg::trap_cause_t irq_cause
);

    // mstatus holds only MIE and MPIE.
    logic                         mstatus_mie;
    logic                         mstatus_mpie;
    trap_types_pkg::irq_mask_t    mie_q;
    trap_types_pkg::tvec_t        mtvec_base;
    logic                         mtvec_mode;
    csr_types_pkg::csr_data_t     mscratch_q;
    trap_types_pkg::epc_t         mepc_q;
    logic                         mcause_irq;
    trap_types_pkg::trap_cause_t  mcause_code;

    // Write strobes per register.
    logic                         wr_mstatus;
    logic                         wr_mie;
    logic                         wr_mtvec;
    logic                         wr_mscratch;
    logic                         wr_mepc;
    logic                         wr_mcause;

    // Pending lines that may actually interrupt.
    trap_types_pkg::irq_mask_t    irq_active;

    // Privilege requirement sits in the address itself.
    assign lk_priv = csr_types_pkg::priv_t'(lk_addr[9:8]);

    // Address decoder.
    always_comb begin
        lk_exists = 1'b1;
        lk_rdonly = 1'b0;
        lk_rdata  = '0;
        case (lk_addr)
            `CSR_ADDR_MSTATUS: begin
                lk_rdata[`MSTATUS_MIE_BIT]  = mstatus_mie;
                lk_rdata[`MSTATUS_MPIE_BIT] = mstatus_mpie;
            end
            `CSR_ADDR_MISA: begin
                lk_rdonly = 1'b1;
                lk_rdata  = `CSR_MISA_VALUE;
            end
            `CSR_ADDR_MIE: begin
                lk_rdata = mie_q;
            end
            `CSR_ADDR_MTVEC: begin
                lk_rdata = {mtvec_base, 1'b0, mtvec_mode};
            end
            `CSR_ADDR_MSCRATCH: begin
                lk_rdata = mscratch_q;
            end
            `CSR_ADDR_MEPC: begin
                lk_rdata = {mepc_q, 2'b00};
            end
            `CSR_ADDR_MCAUSE: begin
                lk_rdata = {mcause_irq, 27'd0, mcause_code};
            end
            `CSR_ADDR_MIP: begin
                // Pending lines are driven from outside, not by software.
                lk_rdonly = 1'b1;
                lk_rdata  = irq_pending & `CSR_IRQ_MASK;
            end
            `CSR_ADDR_MVENDORID: begin
                lk_rdonly = 1'b1;
                lk_rdata  = `CSR_MVENDORID_VALUE;
            end
            `CSR_ADDR_MHARTID: begin
                lk_rdonly = 1'b1;
                lk_rdata  = `CSR_MHARTID_VALUE;
            end
            default: begin
                lk_exists = 1'b0;
            end
        endcase
    end

    assign wr_mstatus  = wr_en && (lk_addr == `CSR_ADDR_MSTATUS);
    assign wr_mie      = wr_en && (lk_addr == `CSR_ADDR_MIE);
    assign wr_mtvec    = wr_en && (lk_addr == `CSR_ADDR_MTVEC);
    assign wr_mscratch = wr_en && (lk_addr == `CSR_ADDR_MSCRATCH);
    assign wr_mepc     = wr_en && (lk_addr == `CSR_ADDR_MEPC);
    assign wr_mcause   = wr_en && (lk_addr == `CSR_ADDR_MCAUSE);

    // Enables and vector.
    // Trap and mret never overlap a CSR write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q        <= '0;
            mtvec_base   <= trap_types_pkg::tvec_t'(`CSR_MTVEC_RESET >> 2);
            mtvec_mode   <= 1'(`CSR_MTVEC_RESET & 32'd1);
        end else if (trap_req) begin
            // Stack the enable and mask interrupts.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (mret_req) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else begin
            if (wr_mstatus) begin
                mstatus_mie  <= wr_data[`MSTATUS_MIE_BIT];
                mstatus_mpie <= wr_data[`MSTATUS_MPIE_BIT];
            end
            // WARL field where only implemented lines stick.
            if (wr_mie) begin
                mie_q <= wr_data & `CSR_IRQ_MASK;
            end
            // Bit 1 of mtvec is hardwired to zero.
            if (wr_mtvec) begin
                mtvec_base <= wr_data[31:2];
                mtvec_mode <= wr_data[0];
            end
        end
    end

    // Scratch, exception PC and cause.
    always_ff @(posedge clk) begin
        if (trap_req) begin
            mepc_q      <= trap_epc;
            mcause_irq  <= trap_irq;
            mcause_code <= trap_cause;
        end else begin
            if (wr_mscratch) begin
                mscratch_q <= wr_data;
            end
            if (wr_mepc) begin
                mepc_q <= wr_data[31:2];
            end
            if (wr_mcause) begin
                mcause_irq  <= wr_data[31];
                mcause_code <= wr_data[3:0];
            end
        end
    end

    // Vectored mode adds cause words to the base for interrupts only.
    assign trap_tvec = (mtvec_mode && trap_irq) ?
                       mtvec_base + trap_types_pkg::tvec_t'(trap_cause) : mtvec_base;

    assign ret_epc = mepc_q;

    assign irq_active = irq_pending & mie_q & `CSR_IRQ_MASK;
    assign irq_take   = mstatus_mie && (|irq_active);

    // External first, then software, then timer.
    always_comb begin
        if (irq_active[`IRQ_MEI]) begin
            irq_cause = trap_types_pkg::trap_cause_t'(`IRQ_MEI);
        end else if (irq_active[`IRQ_MSI]) begin
            irq_cause = trap_types_pkg::trap_cause_t'(`IRQ_MSI);
        end else if (irq_active[`IRQ_MTI]) begin
            irq_cause = trap_types_pkg::trap_cause_t'(`IRQ_MTI);
        end else begin
            irq_cause = '0;
        end
    end

    // The core sequences trap entry and return apart.
    a_trap_mret: assert property (@(posedge clk) disable iff (!arst_n)
        !(trap_req && mret_req));

    // The sequencer filters writes to read-only space.
    a_wr_rdonly: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> !lk_rdonly);

endmodule

// ==== verilog/csr_types_pkg.sv ====
package csr_types_pkg;

    // Twelve-bit CSR address from the instruction immediate.
    // Bits 11:10 mark read-only space, bits 9:8 the minimum privilege.
    typedef logic [11:0] csr_addr_t;

    // One CSR data word.
    // Also used for the rs1 / uimm operand of the access.
    typedef logic [31:0] csr_data_t;

    // Write mode.
    // 01 is write, 10 is set, 11 is clear.
    // 00 means no access and never reaches the unit.
    typedef logic [1:0] csr_wmode_t;

    // Privilege level of the hart.
    // Only user and machine exist here.
    typedef enum logic [1:0] {
        priv_user    = 2'd0,
        priv_machine = 2'd3
    } priv_t;

    // Supervisor encoding (1) is left out on purpose
    // since this hart has no S-mode.
    // Any address with bits 9:8 = 1 or 2 still decodes as not existing,
    // so the value never leaks into a legality check.

endpackage

// ==== verilog/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    // CSR instruction access.
    input  logic                        csr_req,
    input  csr_types_pkg::csr_addr_t    csr_addr,
    input  csr_types_pkg::csr_wmode_t   csr_wmode,
    input  csr_types_pkg::csr_data_t    csr_wmask,
    input  logic                        csr_src_zero,
    input  csr_types_pkg::priv_t        cur_priv,
    output logic                        csr_done,
    output csr_types_pkg::csr_data_t    csr_rdata,
    output logic                        csr_illegal,
    // Trap entry and return.
    input  logic                        trap_req,
    input  logic                        trap_irq,
    input  trap_types_pkg::epc_t        trap_epc,
    input  trap_types_pkg::trap_cause_t trap_cause,
    input  logic                        mret_req,
    output trap_types_pkg::tvec_t       trap_tvec,
    output trap_types_pkg::epc_t        ret_epc,
    // Interrupt gating.
    input  trap_types_pkg::irq_mask_t   irq_pending,
    output logic                        irq_take,
    output trap_types_pkg::trap_cause_t irq_cause
);

    // Lookup and write path between sequencer and register file.
    csr_types_pkg::csr_addr_t  lk_addr;
    logic                      lk_exists;
    logic                      lk_rdonly;
    csr_types_pkg::priv_t      lk_priv;
    csr_types_pkg::csr_data_t  lk_rdata;
    logic                      wr_en;
    csr_types_pkg::csr_data_t  wr_data;

    csr_access_seq u_seq (
        .clk          (clk),
        .arst_n       (arst_n),
        .csr_req      (csr_req),
        .csr_addr     (csr_addr),
        .csr_wmode    (csr_wmode),
        .csr_wmask    (csr_wmask),
        .csr_src_zero (csr_src_zero),
        .cur_priv     (cur_priv),
        .lk_addr      (lk_addr),
        .lk_exists    (lk_exists),
        .lk_rdonly    (lk_rdonly),
        .lk_priv      (lk_priv),
        .lk_rdata     (lk_rdata),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .csr_done     (csr_done),
        .csr_rdata    (csr_rdata),
        .csr_illegal  (csr_illegal)
    );

    csr_regfile u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .lk_addr     (lk_addr),
        .lk_exists   (lk_exists),
        .lk_rdonly   (lk_rdonly),
        .lk_priv     (lk_priv),
        .lk_rdata    (lk_rdata),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .trap_req    (trap_req),
        .trap_irq    (trap_irq),
        .trap_epc    (trap_epc),
        .trap_cause  (trap_cause),
        .mret_req    (mret_req),
        .irq_pending (irq_pending),
        .trap_tvec   (trap_tvec),
        .ret_epc     (ret_epc),
        .irq_take    (irq_take),
        .irq_cause   (irq_cause)
    );

endmodule

// ==== verilog/csr_write_merge.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_write_merge (
    // Operand from rs1 or the zero-extended immediate.
    input  csr_types_pkg::csr_data_t  wmask,
    // Value of the CSR before the access.
    input  csr_types_pkg::csr_data_t  rdata,
    // Access mode.
    input  csr_types_pkg::csr_wmode_t wmode,
    // Value to commit.
    output csr_types_pkg::csr_data_t  wdata
);

    always_comb begin
        case (wmode)
            // Plain write takes the operand as is.
            `CSR_WMODE_WRITE: begin
                wdata = wmask;
            end
            // Set ORs the operand bits into the old value.
            `CSR_WMODE_SET: begin
                wdata = rdata | wmask;
            end
            // Clear removes the operand bits from the old value.
            `CSR_WMODE_CLEAR: begin
                wdata = rdata & ~wmask;
            end
            // No access, the result is don't-care.
            default: begin
                wdata = 'x;
            end
        endcase
    end

endmodule

// ==== verilog/trap_types_pkg.sv ====
package trap_types_pkg;

    // Exception or interrupt code.
    // Four bits cover all machine-mode causes used here.
    typedef logic [3:0] trap_cause_t;

    // Exception program counter, bits 31:2.
    // Instructions are word aligned, so the low bits are not stored.
    typedef logic [31:2] epc_t;

    // Trap vector address, bits 31:2.
    // Vectored mode adds the cause to this word address.
    typedef logic [31:2] tvec_t;

    // One bit per interrupt line.
    // Same layout as mip and mie.
    typedef logic [31:0] irq_mask_t;

    // Only MSI, MTI and MEI are implemented.
    // Other bits read as zero in both mie and mip,
    // since the mask in the consts header strips them.

endpackage
